// File: src/rv_consts.svh
// ============================================================
// Sizing constants of the RV32I execute engine
// ============================================================
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and PC width
`define RV_XLEN 32

// General register count
`define RV_REG_COUNT 32

// Register index width
`define RV_REG_ADDR_W 5

// Micro-op queue depth
`define RV_QUEUE_DEPTH 4

`endif

// File: src/rv_pkg.sv
// ============================================================
// Types shared by decoder, queue and execute unit
// ============================================================
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011
  } opcode_e;

  // Codes are {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_e;

  // Conditional kinds reuse the branch funct3 values
  typedef enum logic [2:0] {
    br_eq   = 3'b000,
    br_ne   = 3'b001,
    br_none = 3'b010,
    br_jump = 3'b011,
    br_lt   = 3'b100,
    br_ge   = 3'b101,
    br_ltu  = 3'b110,
    br_geu  = 3'b111
  } branch_kind_e;

  typedef struct packed {
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
  } instr_in_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    alu_op_e                   alu_op;
    logic                      use_pc;   // First operand is pc
    logic                      use_imm;  // Second operand is imm
    logic                      link;     // Write back pc+4
    logic                      wen;
    branch_kind_e              branch;
  } uop_t;

  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic                      wen;
    logic [`RV_XLEN-1:0]       value;
    logic                      redirect;
    logic [`RV_XLEN-1:0]       target;
  } result_t;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_ack,
    st_wait_release
  } exec_state_e;

endpackage

`default_nettype wire

// File: src/register_file.sv
// ============================================================
// General register file, two async reads and one write
// ============================================================
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module register_file (
  input  wire                      clock,
  input  wire                      reset_n,
  input  wire [`RV_REG_ADDR_W-1:0] rd_addr_a,
  input  wire [`RV_REG_ADDR_W-1:0] rd_addr_b,
  input  wire                      wr_en,
  input  wire [`RV_REG_ADDR_W-1:0] wr_addr,
  input  wire [`RV_XLEN-1:0]       wr_data,
  output logic [`RV_XLEN-1:0]      rd_data_a,
  output logic [`RV_XLEN-1:0]      rd_data_b
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++)
        regs[i] <= '0;
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;  // x0 never written
    end
  end

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
// ============================================================
// Instruction decoder that runs the input handshake and pushes
// decoded RV32I micro-ops into the queue
// ============================================================
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module instr_decoder (
  input  wire                clock,
  input  wire                reset_n,
  input  wire                in_req,
  input  wire rv_pkg::instr_in_t in_data,
  input  wire                full,
  output logic               in_ack,
  output logic               push,
  output rv_pkg::uop_t       push_uop
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                r_ok;
  logic                i_ok;
  rv_pkg::alu_op_e     r_alu;
  rv_pkg::alu_op_e     i_alu;

  assign opcode = rv_pkg::opcode_e'(in_data.instr[6:0]);
  assign f3     = in_data.instr[14:12];
  assign f7     = in_data.instr[31:25];

  assign imm_i = {{20{in_data.instr[31]}}, in_data.instr[31:20]};
  assign imm_b = {{19{in_data.instr[31]}}, in_data.instr[31], in_data.instr[7],
                  in_data.instr[30:25], in_data.instr[11:8], 1'b0};
  assign imm_u = {in_data.instr[31:12], 12'b0};
  assign imm_j = {{11{in_data.instr[31]}}, in_data.instr[31], in_data.instr[19:12],
                  in_data.instr[20], in_data.instr[30:21], 1'b0};

  // funct7 of 0x20 only legal on add/sub and srl/sra
  assign r_ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
  assign i_ok = (f3 == 3'b001) ? (f7 == 7'h00) :
                (f3 == 3'b101) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;

  assign r_alu = rv_pkg::alu_op_e'({in_data.instr[30] && ((f3 == 3'b000) || (f3 == 3'b101)), f3});
  assign i_alu = rv_pkg::alu_op_e'({in_data.instr[30] && (f3 == 3'b101), f3});

  always_comb begin
    push_uop         = '0;
    push_uop.pc      = in_data.pc;
    push_uop.rd      = in_data.instr[11:7];
    push_uop.alu_op  = rv_pkg::alu_add;
    push_uop.branch  = rv_pkg::br_none;
    push_uop.use_imm = 1'b1;  // Unknown opcode adds 0 + 0
    case (opcode)
      rv_pkg::op_reg: begin
        push_uop.rs1     = in_data.instr[19:15];
        push_uop.rs2     = in_data.instr[24:20];
        push_uop.use_imm = 1'b0;
        push_uop.alu_op  = r_alu;
        push_uop.wen     = r_ok;
      end
      rv_pkg::op_imm: begin
        push_uop.rs1    = in_data.instr[19:15];
        push_uop.imm    = imm_i;
        push_uop.alu_op = i_alu;
        push_uop.wen    = i_ok;
      end
      rv_pkg::op_lui: begin
        push_uop.imm = imm_u;  // rs1 stays x0
        push_uop.wen = 1'b1;
      end
      rv_pkg::op_auipc: begin
        push_uop.imm    = imm_u;
        push_uop.use_pc = 1'b1;
        push_uop.wen    = 1'b1;
      end
      rv_pkg::op_jal: begin
        push_uop.imm    = imm_j;
        push_uop.use_pc = 1'b1;
        push_uop.link   = 1'b1;
        push_uop.branch = rv_pkg::br_jump;
        push_uop.wen    = 1'b1;
      end
      rv_pkg::op_jalr: begin
        push_uop.rs1    = in_data.instr[19:15];
        push_uop.imm    = imm_i;
        push_uop.link   = 1'b1;
        push_uop.branch = rv_pkg::br_jump;
        push_uop.wen    = 1'b1;
      end
      rv_pkg::op_branch: begin
        // ALU forms pc+imm while rs1/rs2 go to the compare
        push_uop.rs1    = in_data.instr[19:15];
        push_uop.rs2    = in_data.instr[24:20];
        push_uop.imm    = imm_b;
        push_uop.use_pc = 1'b1;
        if (f3[2:1] != 2'b01)
          push_uop.branch = rv_pkg::branch_kind_e'(f3);
      end
      default: ;
    endcase
  end

  assign push = in_req && !in_ack && !full;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      in_ack <= 1'b0;
    end else if (push) begin
      in_ack <= 1'b1;
    end else if (!in_req) begin
      in_ack <= 1'b0;  // Release phase
    end
  end

endmodule

`default_nettype wire

// File: src/uop_queue.sv
// ============================================================
// Micro-op FIFO between decoder and execute unit
// ============================================================
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module uop_queue #(
  parameter int DEPTH = `RV_QUEUE_DEPTH
) (
  input  wire                clock,
  input  wire                reset_n,
  input  wire                push,
  input  wire rv_pkg::uop_t  push_uop,
  input  wire                pop,
  output rv_pkg::uop_t       head_uop,
  output logic               full,
  output logic               empty
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  rv_pkg::uop_t     storage [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head_uop = storage[rd_ptr];
  assign full     = (count == cnt_w'(DEPTH));
  assign empty    = (count == '0);

  always_ff @(posedge clock) begin
    if (do_push)
      storage[wr_ptr] <= push_uop;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;  // Both at once keeps count
    end
  end

endmodule

`default_nettype wire

// File: src/exec_unit.sv
// ============================================================
// Execute unit: operand select, ALU, branch compare, write back
// and the result handshake
// ============================================================
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module exec_unit (
  input  wire                clock,
  input  wire                reset_n,
  input  wire rv_pkg::uop_t  head_uop,
  input  wire                empty,
  input  wire                res_ack,
  output logic               pop,
  output logic               res_req,
  output rv_pkg::result_t    res_data
);

  localparam logic [`RV_XLEN-1:0] insn_bytes = 4;

  rv_pkg::exec_state_e state;
  rv_pkg::result_t     next_res;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic                taken;
  logic                is_cond;
  logic                fire;

  function automatic logic [`RV_XLEN-1:0] alu_exec(input rv_pkg::alu_op_e op,
                                                   input logic [`RV_XLEN-1:0] a,
                                                   input logic [`RV_XLEN-1:0] b);
    case (op)
      rv_pkg::alu_add:  alu_exec = a + b;
      rv_pkg::alu_sub:  alu_exec = a - b;
      rv_pkg::alu_sll:  alu_exec = a << b[4:0];
      rv_pkg::alu_slt:  alu_exec = ($signed(a) < $signed(b)) ? 1 : 0;
      rv_pkg::alu_sltu: alu_exec = (a < b) ? 1 : 0;
      rv_pkg::alu_xor:  alu_exec = a ^ b;
      rv_pkg::alu_srl:  alu_exec = a >> b[4:0];
      rv_pkg::alu_sra:  alu_exec = $signed(a) >>> b[4:0];  // Sign fill
      rv_pkg::alu_or:   alu_exec = a | b;
      rv_pkg::alu_and:  alu_exec = a & b;
      default:          alu_exec = '0;
    endcase
  endfunction

  function automatic logic branch_exec(input rv_pkg::branch_kind_e kind,
                                       input logic [`RV_XLEN-1:0] a,
                                       input logic [`RV_XLEN-1:0] b);
    case (kind)
      rv_pkg::br_jump: branch_exec = 1'b1;
      rv_pkg::br_eq:   branch_exec = (a == b);
      rv_pkg::br_ne:   branch_exec = (a != b);
      rv_pkg::br_lt:   branch_exec = ($signed(a) < $signed(b));
      rv_pkg::br_ge:   branch_exec = ($signed(a) >= $signed(b));
      rv_pkg::br_ltu:  branch_exec = (a < b);
      rv_pkg::br_geu:  branch_exec = (a >= b);
      default:         branch_exec = 1'b0;
    endcase
  endfunction

  register_file register_file_inst (
    .clock     (clock),
    .reset_n   (reset_n),
    .rd_addr_a (head_uop.rs1),
    .rd_addr_b (head_uop.rs2),
    .wr_en     (fire && head_uop.wen),
    .wr_addr   (head_uop.rd),
    .wr_data   (next_res.value),
    .rd_data_a (rs1_data),
    .rd_data_b (rs2_data)
  );

  assign op_a    = head_uop.use_pc ? head_uop.pc : rs1_data;
  assign op_b    = head_uop.use_imm ? head_uop.imm : rs2_data;
  assign alu_out = alu_exec(head_uop.alu_op, op_a, op_b);
  assign taken   = branch_exec(head_uop.branch, rs1_data, rs2_data);
  assign is_cond = (head_uop.branch != rv_pkg::br_none) &&
                   (head_uop.branch != rv_pkg::br_jump);

  always_comb begin
    next_res.rd       = head_uop.rd;
    next_res.wen      = head_uop.wen;
    next_res.redirect = taken;
    // ALU holds pc+imm or rs1+imm here, bit 0 dropped for JALR
    next_res.target   = taken ? {alu_out[`RV_XLEN-1:1], 1'b0} : '0;
    if (is_cond)
      next_res.value = '0;
    else if (head_uop.link)
      next_res.value = head_uop.pc + insn_bytes;
    else
      next_res.value = alu_out;
  end

  assign fire = (state == rv_pkg::st_idle) && !empty;
  assign pop  = fire;

  always_ff @(posedge clock) begin
    if (fire)
      res_data <= next_res;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state   <= rv_pkg::st_idle;
      res_req <= 1'b0;
    end else begin
      case (state)
        rv_pkg::st_idle: begin
          if (fire) begin
            res_req <= 1'b1;
            state   <= rv_pkg::st_wait_ack;
          end
        end
        rv_pkg::st_wait_ack: begin
          if (res_ack) begin
            res_req <= 1'b0;
            state   <= rv_pkg::st_wait_release;
          end
        end
        rv_pkg::st_wait_release: begin
          if (!res_ack)
            state <= rv_pkg::st_idle;  // Sink released
        end
        default: state <= rv_pkg::st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/rv_exec_top.sv
// ============================================================
// RV32I execute engine top: decoder, queue and execute unit
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module rv_exec_top (
  input  wire                    clock,
  input  wire                    reset_n,
  input  wire                    in_req,
  input  wire rv_pkg::instr_in_t in_data,
  input  wire                    res_ack,
  output logic                   in_ack,
  output logic                   res_req,
  output rv_pkg::result_t        res_data
);

  rv_pkg::uop_t push_uop;
  rv_pkg::uop_t head_uop;
  logic         push;
  logic         pop;
  logic         full;
  logic         empty;

  instr_decoder instr_decoder_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .full     (full),
    .in_ack   (in_ack),
    .push     (push),
    .push_uop (push_uop)
  );

  uop_queue uop_queue_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .push     (push),
    .push_uop (push_uop),
    .pop      (pop),
    .head_uop (head_uop),
    .full     (full),
    .empty    (empty)
  );

  exec_unit exec_unit_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .head_uop (head_uop),
    .empty    (empty),
    .res_ack  (res_ack),
    .pop      (pop),
    .res_req  (res_req),
    .res_data (res_data)
  );

endmodule

`default_nettype wire

// File: bench/tb_rv_exec.sv
// ============================================================
// Testbench for the RV32I execute engine, stimulus and
// expected results read from the vector file
// ============================================================
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module tb_rv_exec;

  localparam int num_vectors   = 40;
  localparam int reset_cycles  = 16;
  localparam int max_ack_delay = 24;  // Long enough to fill the queue
  localparam int cycle_limit   = reset_cycles + 40 * num_vectors;
  localparam int drain_cycles  = 20;

  logic              clock;
  logic              reset_n;
  logic              in_req;
  rv_pkg::instr_in_t in_data;
  logic              res_ack;
  logic              in_ack;
  logic              res_req;
  rv_pkg::result_t   res_data;

  // instr, pc, rd, wen, value, redirect, target
  logic [143:0] vectors [num_vectors];
  int           error_count;
  int           results_seen;
  int           cycle_count;

  rv_exec_top rv_exec_top_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .res_ack  (res_ack),
    .in_ack   (in_ack),
    .res_req  (res_req),
    .res_data (res_data)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  // Inputs change and outputs are read 1 ns after the edge
  task automatic advance_cycle;
    @(posedge clock);
    #1;
  endtask

  task automatic report_mismatch(input int idx, input string field,
                                 input logic [`RV_XLEN-1:0] got,
                                 input logic [`RV_XLEN-1:0] expected);
    $display("Error at %0t ns: vector %0d %s is %h, expected %h",
             $time, idx, field, got, expected);
    error_count++;
  endtask

  task automatic check_result(input int idx, input rv_pkg::result_t got);
    logic [`RV_REG_ADDR_W-1:0] exp_rd;
    logic                      exp_wen;
    logic [`RV_XLEN-1:0]       exp_value;
    logic                      exp_redirect;
    logic [`RV_XLEN-1:0]       exp_target;
    exp_rd       = vectors[idx][76:72];
    exp_wen      = vectors[idx][68];
    exp_value    = vectors[idx][67:36];
    exp_redirect = vectors[idx][32];
    exp_target   = vectors[idx][31:0];
    if (exp_wen && (got.rd !== exp_rd))
      report_mismatch(idx, "rd", `RV_XLEN'(got.rd), `RV_XLEN'(exp_rd));
    if (got.wen !== exp_wen)
      report_mismatch(idx, "wen", `RV_XLEN'(got.wen), `RV_XLEN'(exp_wen));
    if (got.value !== exp_value)
      report_mismatch(idx, "value", got.value, exp_value);
    if (got.redirect !== exp_redirect)
      report_mismatch(idx, "redirect", `RV_XLEN'(got.redirect), `RV_XLEN'(exp_redirect));
    if (got.target !== exp_target)
      report_mismatch(idx, "target", got.target, exp_target);
  endtask

  // Four-phase source side, one instruction per vector in file order
  task automatic drive_instructions;
    int i;
    for (i = 0; i < num_vectors; i++) begin
      in_data.instr = vectors[i][143:112];
      in_data.pc    = vectors[i][111:80];
      in_req        = 1'b1;
      advance_cycle();
      while (!in_ack)
        advance_cycle();
      in_req = 1'b0;
      advance_cycle();
      while (in_ack)
        advance_cycle();
    end
  endtask

  // Sink side with random ack delay
  task automatic collect_results;
    int i;
    int delay;
    for (i = 0; i < num_vectors; i++) begin
      while (!res_req)
        advance_cycle();
      check_result(i, res_data);
      results_seen++;
      delay = $urandom_range(max_ack_delay, 0);
      repeat (delay)
        advance_cycle();
      res_ack = 1'b1;
      advance_cycle();
      while (res_req)
        advance_cycle();
      res_ack = 1'b0;
    end
  endtask

  initial begin
    int i;
    int extra_cycles;
    in_req       = 1'b0;
    in_data      = '0;
    res_ack      = 1'b0;
    reset_n      = 1'b0;
    error_count  = 0;
    results_seen = 0;
    extra_cycles = 0;
    for (i = 0; i < num_vectors; i++)
      vectors[i] = '0;
    $readmemh("bench/exec_vectors.txt", vectors);
    void'($urandom(32'h71db_9cb4));
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset_n = 1'b1;
    advance_cycle();
    if (vectors[num_vectors-1][143:112] == '0) begin
      $display("Vector file is missing or has fewer than %0d lines", num_vectors);
      error_count++;
    end
    if ((in_ack !== 1'b0) || (res_req !== 1'b0)) begin
      $display("Error at %0t ns: in_ack or res_req high after reset", $time);
      error_count++;
    end
    fork
      drive_instructions();
      collect_results();
    join
    repeat (drain_cycles) begin
      advance_cycle();
      if (res_req || in_ack)
        extra_cycles++;  // Duplicate or stray handshake
    end
    if (extra_cycles != 0) begin
      $display("Handshake activity seen after the last result was taken");
      error_count++;
    end
    $display("Results: %0d of %0d, errors: %0d", results_seen, num_vectors, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles with only %0d of %0d results",
             cycle_limit, results_seen, num_vectors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/exec_vectors.txt
// instr_pc_rd_wen_value_redirect_target in hex; rd is compared only where wen is 1
// x1 = 5 and x2 = -3 feed the later ALU, branch and jump lines
00500093_00000100_01_1_00000005_0_00000000 // addi x1, x0, 5
FFD00113_00000104_02_1_FFFFFFFD_0_00000000 // addi x2, x0, -3
002081B3_00000108_03_1_00000002_0_00000000 // add x3, x1, x2
40208233_0000010C_04_1_00000008_0_00000000 // sub x4, x1, x2
001122B3_00000110_05_1_00000001_0_00000000 // slt x5, x2, x1
00113333_00000114_06_1_00000000_0_00000000 // sltu x6, x2, x1
40115393_00000118_07_1_FFFFFFFE_0_00000000 // srai x7, x2, 1
00115413_0000011C_08_1_7FFFFFFE_0_00000000 // srli x8, x2, 1
00409493_00000120_09_1_00000050_0_00000000 // slli x9, x1, 4
FFF0C513_00000124_0A_1_FFFFFFFA_0_00000000 // xori x10, x1, -1
0014E5B3_00000128_0B_1_00000055_0_00000000 // or x11, x9, x1
00F5F613_0000012C_0C_1_00000005_0_00000000 // andi x12, x11, 15
FFE12693_00000130_0D_1_00000001_0_00000000 // slti x13, x2, -2
FFF0B713_00000134_0E_1_00000001_0_00000000 // sltiu x14, x1, -1
409157B3_00000138_0F_1_FFFFFFFF_0_00000000 // sra x15, x2, x9
00915833_0000013C_10_1_0000FFFF_0_00000000 // srl x16, x2, x9
123458B7_00000140_11_1_12345000_0_00000000 // lui x17, 0x12345
00001917_00000144_12_1_00001144_0_00000000 // auipc x18, 1
00108863_00000148_00_0_00000000_1_00000158 // beq x1, x1, +16
00109863_0000014C_00_0_00000000_0_00000000 // bne x1, x1, +16
FE114CE3_00000150_00_0_00000000_1_00000148 // blt x2, x1, -8
00115863_00000154_00_0_00000000_0_00000000 // bge x2, x1, +16
00116863_00000158_00_0_00000000_0_00000000 // bltu x2, x1, +16
00117863_0000015C_00_0_00000000_1_0000016C // bgeu x2, x1, +16
00208863_00000160_00_0_00000000_0_00000000 // beq x1, x2, +16
00209863_00000164_00_0_00000000_1_00000174 // bne x1, x2, +16
0020C863_00000168_00_0_00000000_0_00000000 // blt x1, x2, +16
FE20DCE3_0000016C_00_0_00000000_1_00000164 // bge x1, x2, -8
0020E863_00000170_00_0_00000000_1_00000180 // bltu x1, x2, +16
0020F863_00000174_00_0_00000000_0_00000000 // bgeu x1, x2, +16
020009EF_00000178_13_1_0000017C_1_00000198 // jal x19, +32
10008A67_0000017C_14_1_00000180_1_00000104 // jalr x20, 0x100(x1)
00708013_00000180_00_1_0000000C_0_00000000 // addi x0, x1, 7
00008AB3_00000184_15_1_00000005_0_00000000 // add x21, x1, x0
022084B3_00000188_09_0_00000002_0_00000000 // funct7 0x01 on add, x9 kept
40209493_0000018C_09_0_00000014_0_00000000 // slli x9 with funct7 0x20
00048B13_00000190_16_1_00000050_0_00000000 // addi x22, x9, 0
00000073_00000194_00_0_00000000_0_00000000 // ecall as unknown opcode
0000000F_00000198_00_0_00000000_0_00000000 // fence as unknown opcode
40110BB3_0000019C_17_1_FFFFFFF8_0_00000000 // sub x23, x2, x1

// File: all.f
+incdir+src
src/rv_pkg.sv
src/register_file.sv
src/instr_decoder.sv
src/uop_queue.sv
src/exec_unit.sv
src/rv_exec_top.sv
bench/tb_rv_exec.sv

// File: run.sh
#!/bin/sh
# Build and run the execute engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -j 0 \
  --top-module tb_rv_exec -f all.f -o tb_rv_exec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_rv_exec)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Testbench passed$"; then
  exit 0
fi
exit 1
